// ==== hw/regdisp_pkg.sv ====
package regdisp_pkg;

    //////////////////////////////////////////////////
    // bus geometry
    //////////////////////////////////////////////////

    // default widths of the native bus.
    localparam int unsigned DEF_ADDR_WIDTH = 32;
    localparam int unsigned DEF_DATA_WIDTH = 32;

    //////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////

    // region number lives in addr[top:REGION_LSB].
    localparam int unsigned REGION_LSB = 12;

    // local register file.
    localparam int unsigned REGION_LOCAL = 0;
    // third-party IP behind the bridge.
    localparam int unsigned REGION_EXT = 1;

    // where a decoded request goes.
    typedef enum logic [1:0] {
        target_local = 2'd0,
        target_ext   = 2'd1,
        target_none  = 2'd2
    } regdisp_target_e;

    // control FSM states.
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_local = 2'd1,
        st_ext   = 2'd2,
        st_resp  = 2'd3
    } regdisp_state_e;

    //////////////////////////////////////////////////
    // response values
    //////////////////////////////////////////////////

    // read data on unmapped or timed-out accesses.
    localparam logic [31:0] ERR_DATA = 32'hBAD0_ADD5;

    // identification word, register index 15.
    localparam logic [31:0] REGDISP_ID = 32'h5244_0100;

    // cycles an external request may stay unanswered.
    localparam int unsigned DEF_TIMEOUT = 64;

endpackage

// ==== hw/reg_native_if.sv ====
interface reg_native_if import regdisp_pkg::*; #(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int DATA_WIDTH = DEF_DATA_WIDTH
);

    // request side, valid in the req_vld cycle.
    logic                  req_vld;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  wr_en;
    logic                  rd_en;
    logic [DATA_WIDTH-1:0] wr_data;

    // acknowledge side, valid in the ack_vld cycle.
    logic                  ack_vld;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  err;

    modport requester (
        output req_vld, addr, wr_en, rd_en, wr_data,
        input  ack_vld, rd_data, err
    );

    modport responder (
        input  req_vld, addr, wr_en, rd_en, wr_data,
        output ack_vld, rd_data, err
    );

endinterface

// ==== hw/pulse_deliver.sv ====
module pulse_deliver #(
    parameter type payload_t = logic
) (
    // source domain.
    input  logic     clk_a,
    input  logic     rst_a_n,
    input  logic     pulse_in,
    input  payload_t data_in,
    // destination domain.
    input  logic     clk_b,
    input  logic     rst_b_n,
    output logic     pulse_out,
    output payload_t data_out
);

    //////////////////////////////////////////////////
    // domain a
    //////////////////////////////////////////////////

    logic     tog_a;
    payload_t hold_a;

    // one toggle per pulse.
    always_ff @(posedge clk_a) begin
        if (!rst_a_n) begin
            tog_a <= 1'b0;
        end else if (pulse_in) begin
            tog_a <= ~tog_a;
        end
    end

    // payload stays put until the next pulse.
    always_ff @(posedge clk_a) begin
        if (pulse_in) begin
            hold_a <= data_in;
        end
    end

    //////////////////////////////////////////////////
    // domain b
    //////////////////////////////////////////////////

    logic [1:0] tog_sync;
    logic       tog_seen;
    logic       tog_edge;

    // two-flop synchroniser, then edge detect.
    always_ff @(posedge clk_b) begin
        if (!rst_b_n) begin
            tog_sync  <= 2'b00;
            tog_seen  <= 1'b0;
            pulse_out <= 1'b0;
        end else begin
            tog_sync  <= {tog_sync[0], tog_a};
            tog_seen  <= tog_sync[1];
            pulse_out <= tog_edge;
        end
    end

    assign tog_edge = tog_sync[1] ^ tog_seen;

    // hold_a has been stable for two clk_b cycles here.
    always_ff @(posedge clk_b) begin
        if (tog_edge) begin
            data_out <= hold_a;
        end
    end

endmodule

// ==== hw/reg_native_if2third_party_ip.sv ====
module reg_native_if2third_party_ip import regdisp_pkg::*; #(
    parameter int BUS_ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int BUS_DATA_WIDTH = DEF_DATA_WIDTH,
    parameter bit CDC_ENABLE     = 1'b0
) (
    // native side.
    input  logic                      native_clk,
    input  logic                      rst_n,
    reg_native_if.responder           bus,
    // third-party IP side.
    input  logic                      ext_clk,
    input  logic                      ext_rst_n,
    output logic                      ext_req_vld,
    output logic [BUS_ADDR_WIDTH-1:0] ext_addr,
    output logic                      ext_wr_en,
    output logic                      ext_rd_en,
    output logic [BUS_DATA_WIDTH-1:0] ext_wr_data,
    input  logic                      ext_ack_vld,
    input  logic [BUS_DATA_WIDTH-1:0] ext_rd_data
);

    // request payload, native to ext.
    typedef struct packed {
        logic [BUS_ADDR_WIDTH-1:0] addr;
        logic                      wr_en;
        logic                      rd_en;
        logic [BUS_DATA_WIDTH-1:0] wr_data;
    } fwd_t;

    // acknowledge payload, ext to native.
    typedef struct packed {
        logic [BUS_DATA_WIDTH-1:0] rd_data;
    } bwd_t;

    fwd_t fwd_in;
    fwd_t fwd_out;
    bwd_t bwd_in;
    bwd_t bwd_out;

    // the IP only sees the offset inside its region.
    assign fwd_in.addr    = BUS_ADDR_WIDTH'(bus.addr[REGION_LSB-1:0]);
    assign fwd_in.wr_en   = bus.wr_en;
    assign fwd_in.rd_en   = bus.rd_en;
    assign fwd_in.wr_data = bus.wr_data;
    assign bwd_in.rd_data = ext_rd_data;

    assign {ext_addr, ext_wr_en, ext_rd_en, ext_wr_data} = fwd_out;
    assign bus.rd_data = bwd_out.rd_data;
    // the IP has no error signal.
    assign bus.err = 1'b0;

    //////////////////////////////////////////////////
    // clock domain crossing
    //////////////////////////////////////////////////

    generate
        if (CDC_ENABLE) begin : g_cdc
            pulse_deliver #(
                .payload_t (fwd_t)
            ) u_fwd (
                .clk_a     (native_clk),
                .rst_a_n   (rst_n),
                .pulse_in  (bus.req_vld),
                .data_in   (fwd_in),
                .clk_b     (ext_clk),
                .rst_b_n   (ext_rst_n),
                .pulse_out (ext_req_vld),
                .data_out  (fwd_out)
            );

            pulse_deliver #(
                .payload_t (bwd_t)
            ) u_bwd (
                .clk_a     (ext_clk),
                .rst_a_n   (ext_rst_n),
                .pulse_in  (ext_ack_vld),
                .data_in   (bwd_in),
                .clk_b     (native_clk),
                .rst_b_n   (rst_n),
                .pulse_out (bus.ack_vld),
                .data_out  (bwd_out)
            );
        end else begin : g_no_cdc
            // same clock on both sides.
            assign ext_req_vld = bus.req_vld;
            assign fwd_out     = fwd_in;
            assign bus.ack_vld = ext_ack_vld;
            assign bwd_out     = bwd_in;
        end
    endgenerate

endmodule

// ==== hw/regdisp_regfile.sv ====
module regdisp_regfile import regdisp_pkg::*; #(
    parameter int BUS_DATA_WIDTH = DEF_DATA_WIDTH
) (
    input logic             native_clk,
    input logic             rst_n,
    reg_native_if.responder bus
);

    localparam int NUM_WORDS = 16;
    localparam int ID_INDEX  = NUM_WORDS - 1;

    // words 0..14 are scratch, 15 is the ID.
    logic [BUS_DATA_WIDTH-1:0] scratch [ID_INDEX];
    logic [3:0]                idx;
    logic                      wr_hit;

    // word index from byte address.
    assign idx    = bus.addr[5:2];
    assign wr_hit = bus.req_vld && bus.wr_en && (idx != 4'(ID_INDEX));

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge native_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ID_INDEX; i++) begin
                scratch[i] <= '0;
            end
        end else if (wr_hit) begin
            scratch[idx] <= bus.wr_data;
        end
    end

    //////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////

    // one-cycle ack for every request.
    always_ff @(posedge native_clk) begin
        if (!rst_n) begin
            bus.ack_vld <= 1'b0;
        end else begin
            bus.ack_vld <= bus.req_vld;
        end
    end

    // registered read data.
    always_ff @(posedge native_clk) begin
        if (bus.req_vld && bus.rd_en) begin
            if (idx == 4'(ID_INDEX)) begin
                bus.rd_data <= BUS_DATA_WIDTH'(REGDISP_ID);
            end else begin
                bus.rd_data <= scratch[idx];
            end
        end
    end

    // every local access is legal.
    assign bus.err = 1'b0;

endmodule

// ==== hw/regdisp_ctrl.sv ====
module regdisp_ctrl import regdisp_pkg::*; #(
    parameter int BUS_ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int BUS_DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int TIMEOUT_CYCLES = DEF_TIMEOUT
) (
    input  logic                      native_clk,
    input  logic                      rst_n,
    // host request.
    input  logic                      req_vld,
    input  logic [BUS_ADDR_WIDTH-1:0] addr,
    input  logic                      wr_en,
    input  logic                      rd_en,
    input  logic [BUS_DATA_WIDTH-1:0] wr_data,
    // host response.
    output logic                      ack_vld,
    output logic [BUS_DATA_WIDTH-1:0] rd_data,
    output logic                      err,
    // targets.
    reg_native_if.requester           loc_bus,
    reg_native_if.requester           ext_bus
);

    localparam int REGION_W = BUS_ADDR_WIDTH - REGION_LSB;
    localparam int CNT_W    = $clog2(TIMEOUT_CYCLES + 1);

    regdisp_state_e            state;
    regdisp_target_e           target;
    logic [REGION_W-1:0]       region;
    logic [CNT_W-1:0]          wait_cnt;
    logic                      loc_req;
    logic                      ext_req;
    logic                      accept;
    logic [BUS_ADDR_WIDTH-1:0] req_addr;
    logic                      req_wr_en;
    logic                      req_rd_en;
    logic [BUS_DATA_WIDTH-1:0] req_wr_data;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    assign region = addr[BUS_ADDR_WIDTH-1:REGION_LSB];
    // requests outside idle are dropped.
    assign accept = req_vld && (state == st_idle);

    always_comb begin
        if (region == REGION_W'(REGION_LOCAL)) begin
            target = target_local;
        end else if (region == REGION_W'(REGION_EXT)) begin
            target = target_ext;
        end else begin
            target = target_none;
        end
    end

    //////////////////////////////////////////////////
    // sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge native_clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            loc_req  <= 1'b0;
            ext_req  <= 1'b0;
            ack_vld  <= 1'b0;
            err      <= 1'b0;
            wait_cnt <= '0;
        end else begin
            loc_req <= 1'b0;
            ext_req <= 1'b0;
            ack_vld <= 1'b0;
            err     <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        wait_cnt <= '0;
                        case (target)
                            target_local: begin
                                state   <= st_local;
                                loc_req <= 1'b1;
                            end
                            target_ext: begin
                                state   <= st_ext;
                                ext_req <= 1'b1;
                            end
                            default: state <= st_resp;
                        endcase
                    end
                end
                st_local: begin
                    if (loc_bus.ack_vld) begin
                        ack_vld <= 1'b1;
                        err     <= loc_bus.err;
                        state   <= st_idle;
                    end
                end
                st_ext: begin
                    if (ext_bus.ack_vld) begin
                        ack_vld <= 1'b1;
                        err     <= ext_bus.err;
                        state   <= st_idle;
                    end else if (wait_cnt == CNT_W'(TIMEOUT_CYCLES - 1)) begin
                        // silent IP, answer with an error.
                        state <= st_resp;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                st_resp: begin
                    ack_vld <= 1'b1;
                    err     <= 1'b1;
                    state   <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request payload, held while outstanding.
    always_ff @(posedge native_clk) begin
        if (accept) begin
            req_addr    <= addr;
            req_wr_en   <= wr_en;
            req_rd_en   <= rd_en;
            req_wr_data <= wr_data;
        end
    end

    // response data mux.
    always_ff @(posedge native_clk) begin
        if (state == st_local && loc_bus.ack_vld) begin
            rd_data <= loc_bus.rd_data;
        end else if (state == st_ext && ext_bus.ack_vld) begin
            rd_data <= ext_bus.rd_data;
        end else if (state == st_resp) begin
            rd_data <= BUS_DATA_WIDTH'(ERR_DATA);
        end
    end

    //////////////////////////////////////////////////
    // target buses
    //////////////////////////////////////////////////

    assign loc_bus.req_vld = loc_req;
    assign loc_bus.addr    = req_addr;
    assign loc_bus.wr_en   = req_wr_en;
    assign loc_bus.rd_en   = req_rd_en;
    assign loc_bus.wr_data = req_wr_data;

    assign ext_bus.req_vld = ext_req;
    assign ext_bus.addr    = req_addr;
    assign ext_bus.wr_en   = req_wr_en;
    assign ext_bus.rd_en   = req_rd_en;
    assign ext_bus.wr_data = req_wr_data;

endmodule

// ==== hw/regdisp_top.sv ====
module regdisp_top import regdisp_pkg::*; #(
    parameter int BUS_ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int BUS_DATA_WIDTH = DEF_DATA_WIDTH,
    parameter bit CDC_ENABLE     = 1'b0,
    parameter int TIMEOUT_CYCLES = DEF_TIMEOUT
) (
    // host, native_clk domain.
    input  logic                      native_clk,
    input  logic                      rst_n,
    input  logic                      req_vld,
    input  logic [BUS_ADDR_WIDTH-1:0] addr,
    input  logic                      wr_en,
    input  logic                      rd_en,
    input  logic [BUS_DATA_WIDTH-1:0] wr_data,
    output logic                      ack_vld,
    output logic [BUS_DATA_WIDTH-1:0] rd_data,
    output logic                      err,
    // third-party IP, ext_clk domain.
    input  logic                      ext_clk,
    input  logic                      ext_rst_n,
    output logic                      ext_req_vld,
    output logic [BUS_ADDR_WIDTH-1:0] ext_addr,
    output logic                      ext_wr_en,
    output logic                      ext_rd_en,
    output logic [BUS_DATA_WIDTH-1:0] ext_wr_data,
    input  logic                      ext_ack_vld,
    input  logic [BUS_DATA_WIDTH-1:0] ext_rd_data
);

    reg_native_if #(
        .ADDR_WIDTH (BUS_ADDR_WIDTH),
        .DATA_WIDTH (BUS_DATA_WIDTH)
    ) loc_bus ();

    reg_native_if #(
        .ADDR_WIDTH (BUS_ADDR_WIDTH),
        .DATA_WIDTH (BUS_DATA_WIDTH)
    ) ext_bus ();

    regdisp_ctrl #(
        .BUS_ADDR_WIDTH (BUS_ADDR_WIDTH),
        .BUS_DATA_WIDTH (BUS_DATA_WIDTH),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_ctrl (
        .native_clk (native_clk),
        .rst_n      (rst_n),
        .req_vld    (req_vld),
        .addr       (addr),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .wr_data    (wr_data),
        .ack_vld    (ack_vld),
        .rd_data    (rd_data),
        .err        (err),
        .loc_bus    (loc_bus.requester),
        .ext_bus    (ext_bus.requester)
    );

    regdisp_regfile #(
        .BUS_DATA_WIDTH (BUS_DATA_WIDTH)
    ) u_regfile (
        .native_clk (native_clk),
        .rst_n      (rst_n),
        .bus        (loc_bus.responder)
    );

    reg_native_if2third_party_ip #(
        .BUS_ADDR_WIDTH (BUS_ADDR_WIDTH),
        .BUS_DATA_WIDTH (BUS_DATA_WIDTH),
        .CDC_ENABLE     (CDC_ENABLE)
    ) u_ext_bridge (
        .native_clk  (native_clk),
        .rst_n       (rst_n),
        .bus         (ext_bus.responder),
        .ext_clk     (ext_clk),
        .ext_rst_n   (ext_rst_n),
        .ext_req_vld (ext_req_vld),
        .ext_addr    (ext_addr),
        .ext_wr_en   (ext_wr_en),
        .ext_rd_en   (ext_rd_en),
        .ext_wr_data (ext_wr_data),
        .ext_ack_vld (ext_ack_vld),
        .ext_rd_data (ext_rd_data)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter real PERIOD_NS = 10.0,
    parameter real OFFSET_NS = 0.0
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // low during the offset, then free running.
    initial begin
        clk = 1'b0;
        #(OFFSET_NS);
        forever begin
            #(PERIOD_NS / 2.0);
            clk = ~clk;
        end
    end

endmodule

// ==== dv/regdisp_tb.sv ====
module regdisp_tb import regdisp_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 40;
    localparam int ACK_LIMIT      = TIMEOUT_CYCLES + 20;

    // external round trip, two crossings of about three cycles each,
    // the IP delay, the request register and the response register.
    localparam int XING_MIN_CYC = 2;
    localparam int XING_MAX_CYC = 4;
    localparam int IP_MAX_DELAY = 6;
    localparam int EXT_MIN_CYC  = 2 * XING_MIN_CYC + 2;
    localparam int EXT_MAX_CYC  = 2 * XING_MAX_CYC + IP_MAX_DELAY + 2;

    logic        native_clk;
    logic        ext_clk;
    logic        rst_n;
    logic        ext_rst_n;
    logic        req_vld;
    logic [31:0] addr;
    logic        wr_en;
    logic        rd_en;
    logic [31:0] wr_data;
    logic        ack_vld;
    logic [31:0] rd_data;
    logic        err;
    logic        ext_req_vld;
    logic [31:0] ext_addr;
    logic        ext_wr_en;
    logic        ext_rd_en;
    logic [31:0] ext_wr_data;
    logic        ext_ack_vld;
    logic [31:0] ext_rd_data;

    // host side bookkeeping.
    logic        busy;
    logic        ext_pending;
    logic [31:0] exp_ext_offset;
    logic        exp_ext_wr;
    logic [31:0] exp_ext_wdata;
    int          req_count;
    int          ack_count = 0;
    logic [31:0] ref_loc [16];
    logic [31:0] ref_ext [256];
    logic [31:0] ip_mem  [256];

    tb_clk_gen #(.PERIOD_NS(10.0), .OFFSET_NS(0.0)) u_native_clk (.clk(native_clk));
    tb_clk_gen #(.PERIOD_NS(10.0), .OFFSET_NS(3.0)) u_ext_clk (.clk(ext_clk));

    regdisp_top #(
        .CDC_ENABLE     (1'b1),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) DUT (.*);

    //////////////////////////////////////////////////
    // error reporting
    //////////////////////////////////////////////////

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_on_error($sformatf("CHECK FAILED at %0.1f ns: %s got 0x%08h expected 0x%08h",
                                $realtime, sig, got, exp));
    endtask

    // initial external contents, a function of the word index.
    function automatic logic [31:0] ext_fill(input int unsigned idx);
        return {8'hE0, idx[7:0], ~idx[7:0], 8'(idx * 7)};
    endfunction

    //////////////////////////////////////////////////
    // protocol assertions
    //////////////////////////////////////////////////

    // no response while idle.
    assert property (@(posedge native_clk) disable iff (!rst_n) !busy |-> !ack_vld && !err)
        else stop_on_error("ack_vld or err raised with no request outstanding");

    // one pulse per response.
    assert property (@(posedge native_clk) disable iff (!rst_n) ack_vld |=> !ack_vld)
        else stop_on_error("ack_vld held high for more than one cycle");

    assert property (@(posedge ext_clk) disable iff (!ext_rst_n) ext_req_vld |-> ext_pending)
        else stop_on_error("ext_req_vld pulsed with no external request outstanding");

    always @(posedge native_clk) begin
        if (rst_n && ack_vld) begin
            ack_count <= ack_count + 1;
        end
    end

    //////////////////////////////////////////////////
    // external IP model
    //////////////////////////////////////////////////

    initial begin : ext_ip_model
        int          delay;
        logic [7:0]  word;
        logic [31:0] data;
        delay       = 0;
        data        = '0;
        ext_ack_vld = 1'b0;
        ext_rd_data = '0;
        for (int i = 0; i < 256; i++) begin
            ip_mem[i] = ext_fill(i);
        end
        forever begin
            @(posedge ext_clk);
            #1;
            ext_ack_vld = 1'b0;
            if (delay > 0) begin
                delay--;
                if (delay == 0) begin
                    ext_ack_vld = 1'b1;
                    ext_rd_data = data;
                end
            end
            if (ext_rst_n && ext_req_vld) begin
                assert (ext_addr == exp_ext_offset)
                    else report_mismatch("ext_addr", ext_addr, exp_ext_offset);
                assert (ext_wr_en == exp_ext_wr)
                    else report_mismatch("ext_wr_en", 32'(ext_wr_en), 32'(exp_ext_wr));
                assert (ext_rd_en == !exp_ext_wr)
                    else report_mismatch("ext_rd_en", 32'(ext_rd_en), 32'(!exp_ext_wr));
                if (exp_ext_wr) begin
                    assert (ext_wr_data == exp_ext_wdata)
                        else report_mismatch("ext_wr_data", ext_wr_data, exp_ext_wdata);
                end
                word = ext_addr[9:2];
                if (ext_wr_en) begin
                    ip_mem[word] = ext_wr_data;
                end
                data = ip_mem[word];
                // offset 0xFFC stays silent.
                if (ext_addr[11:0] != 12'hFFC) begin
                    delay = 1 + int'($urandom % IP_MAX_DELAY);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // host driver
    //////////////////////////////////////////////////

    // one request, then checks on the response and its latency.
    task automatic run_access(input logic [31:0] a, input logic is_wr,
                              input logic [31:0] wdata, input logic [31:0] exp_rd,
                              input logic exp_err, input int min_cyc, input int max_cyc);
        int n;
        n         = 0;
        busy      = 1'b1;
        req_count++;
        req_vld   = 1'b1;
        addr      = a;
        wr_en     = is_wr;
        rd_en     = !is_wr;
        wr_data   = wdata;
        do begin
            @(posedge native_clk);
            #1;
            req_vld = 1'b0;
            n++;
        end while (!ack_vld && n < ACK_LIMIT);
        if (!ack_vld) begin
            stop_on_error($sformatf("no ack_vld within %0d cycles of the request, ctrl in %s",
                                    ACK_LIMIT, DUT.u_ctrl.state.name()));
        end
        assert (n >= min_cyc && n <= max_cyc)
            else stop_on_error($sformatf(
                "CHECK FAILED at %0.1f ns: ack_vld latency got %0d expected %0d to %0d",
                $realtime, n, min_cyc, max_cyc));
        assert (err == exp_err) else report_mismatch("err", 32'(err), 32'(exp_err));
        if (!is_wr || exp_err) begin
            assert (rd_data == exp_rd) else report_mismatch("rd_data", rd_data, exp_rd);
        end
        @(posedge native_clk);
        #1;
        busy = 1'b0;
    endtask

    task automatic local_op(input int unsigned idx, input logic is_wr);
        logic [31:0] wdata;
        wdata = $urandom;
        run_access(32'(idx) << 2, is_wr, wdata,
                   (idx == 15) ? REGDISP_ID : ref_loc[idx], 1'b0, 3, 3);
        if (is_wr && idx != 15) begin
            ref_loc[idx] = wdata;
        end
    endtask

    task automatic ext_op(input int unsigned word, input logic is_wr);
        logic [31:0] wdata;
        wdata          = $urandom;
        exp_ext_offset = 32'(word) << 2;
        exp_ext_wr     = is_wr;
        exp_ext_wdata  = wdata;
        ext_pending    = 1'b1;
        run_access(32'h1000 | exp_ext_offset, is_wr, wdata, ref_ext[word], 1'b0,
                   EXT_MIN_CYC, EXT_MAX_CYC);
        ext_pending = 1'b0;
        if (is_wr) begin
            ref_ext[word] = wdata;
        end
    endtask

    // bit 13 set puts the region at 2 or above.
    task automatic unmapped_op(input logic is_wr);
        logic [31:0] a;
        a = ($urandom | 32'h0000_2000) & 32'hFFFF_FFFC;
        run_access(a, is_wr, $urandom, ERR_DATA, 1'b1, 2, 2);
    endtask

    task automatic timeout_op();
        exp_ext_offset = 32'h0000_0FFC;
        exp_ext_wr     = 1'b0;
        exp_ext_wdata  = '0;
        ext_pending    = 1'b1;
        run_access(32'h0000_1FFC, 1'b0, '0, ERR_DATA, 1'b1, TIMEOUT_CYCLES, TIMEOUT_CYCLES + 3);
        ext_pending = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin : main
        void'($urandom(75064));
        rst_n          = 1'b0;
        ext_rst_n      = 1'b0;
        req_vld        = 1'b0;
        addr           = '0;
        wr_en          = 1'b0;
        rd_en          = 1'b0;
        wr_data        = '0;
        busy           = 1'b0;
        ext_pending    = 1'b0;
        exp_ext_offset = '0;
        exp_ext_wr     = 1'b0;
        exp_ext_wdata  = '0;
        req_count      = 0;
        for (int i = 0; i < 16; i++) begin
            ref_loc[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            ref_ext[i] = ext_fill(i);
        end
        repeat (5) @(posedge native_clk);
        #1;
        rst_n     = 1'b1;
        ext_rst_n = 1'b1;
        // quiet period after reset.
        repeat (8) @(posedge native_clk);
        #1;
        assert (DUT.u_ctrl.state == st_idle)
            else stop_on_error($sformatf("ctrl in %s after reset instead of st_idle",
                                         DUT.u_ctrl.state.name()));
        for (int i = 0; i < 16; i++) begin
            local_op(i, 1'b1);
        end
        for (int i = 0; i < 16; i++) begin
            local_op(i, 1'b0);
        end
        repeat (24) ext_op($urandom % 256, 1'($urandom));
        repeat (4) unmapped_op(1'($urandom));
        timeout_op();
        ext_op($urandom % 256, 1'b0);
        local_op(15, 1'b0);
        // mixed traffic.
        repeat (40) begin
            case ($urandom % 3)
                0: local_op($urandom % 16, 1'($urandom));
                1: ext_op($urandom % 256, 1'($urandom));
                default: unmapped_op(1'($urandom));
            endcase
        end
        if (ack_count == req_count) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_mismatch("ack_vld count", 32'(ack_count), 32'(req_count));
        end
    end

endmodule

// ==== verilog.f ====
hw/regdisp_pkg.sv
hw/reg_native_if.sv
hw/pulse_deliver.sv
hw/reg_native_if2third_party_ip.sv
hw/regdisp_regfile.sv
hw/regdisp_ctrl.sv
hw/regdisp_top.sv
dv/tb_clk_gen.sv
dv/regdisp_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := regdisp_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
